/* design/rv_trace_pkg.sv */
package rv_trace_pkg;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OPC_LUI   = 7'b0110111,
        OPC_AUIPC = 7'b0010111,
        OPC_JAL   = 7'b1101111,
        OPC_JALR  = 7'b1100111,
        OPC_B     = 7'b1100011,  // Conditional branches
        OPC_IL    = 7'b0000011,  // Loads
        OPC_S     = 7'b0100011,  // Stores
        OPC_I     = 7'b0010011,  // Register-immediate ALU
        OPC_R     = 7'b0110011,  // Register-register ALU
        OPC_FENCE = 7'b0001111,
        OPC_E     = 7'b1110011   // ECALL, EBREAK
    } opcode_t;

    typedef logic [9:0] funct_t;  // {funct7, funct3}

    localparam funct_t FN_ADD  = {7'b0000000, 3'b000};
    localparam funct_t FN_SUB  = {7'b0100000, 3'b000};
    localparam funct_t FN_SLL  = {7'b0000000, 3'b001};
    localparam funct_t FN_SLT  = {7'b0000000, 3'b010};
    localparam funct_t FN_SLTU = {7'b0000000, 3'b011};
    localparam funct_t FN_XOR  = {7'b0000000, 3'b100};
    localparam funct_t FN_SRL  = {7'b0000000, 3'b101};
    localparam funct_t FN_SRA  = {7'b0100000, 3'b101};
    localparam funct_t FN_OR   = {7'b0000000, 3'b110};
    localparam funct_t FN_AND  = {7'b0000000, 3'b111};
    // Immediate shifts keep the shift type in funct7
    localparam funct_t FN_SLLI = {7'b0000000, 3'b001};
    localparam funct_t FN_SRLI = {7'b0000000, 3'b101};
    localparam funct_t FN_SRAI = {7'b0100000, 3'b101};

    typedef logic [31:0] inst_t;
    typedef logic [31:0] addr_t;

    typedef struct packed {
        inst_t inst;
        addr_t pc;
        logic  legal;
        logic  bubble;
    } stage_t;

    localparam inst_t  NOP        = 32'h0000_0013;  // addi x0, x0, 0
    localparam addr_t  PC_INIT    = 32'h0000_0200;
    localparam stage_t STAGE_INIT = '{inst: NOP, pc: PC_INIT, legal: 1'b1, bubble: 1'b1};

    // APB register map
    localparam addr_t REG_CTRL    = 32'h0000_0000;
    localparam addr_t REG_RETIRED = 32'h0000_0004;
    localparam addr_t REG_ILLEGAL = 32'h0000_0008;
    localparam addr_t REG_LAST_PC = 32'h0000_000C;
    localparam addr_t REG_WB_INST = 32'h0000_0010;
    localparam addr_t REG_WB_PC   = 32'h0000_0014;

endpackage

/* design/rv_inst_legality.sv */
`timescale 1ns/1ps

module rv_inst_legality (
    input  rv_trace_pkg::inst_t inst_i,
    output logic                legal_o
);

    rv_trace_pkg::opcode_t opcode;
    rv_trace_pkg::funct_t  funct;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [11:0]           imm_i;
    logic [20:0]           imm_j;
    logic [12:0]           imm_b;
    logic                  sys_ok;

    assign opcode = rv_trace_pkg::opcode_t'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign funct  = {funct7, funct3};

    // Immediates rebuilt in architectural bit order
    assign imm_i = inst_i[31:20];
    assign imm_j = {inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_b = {inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

    // ECALL and EBREAK differ only in bit 20
    assign sys_ok = (inst_i[31:21] == 11'd0) && (inst_i[19:7] == 13'd0);

    always_comb begin
        case (opcode)
            rv_trace_pkg::OPC_LUI,
            rv_trace_pkg::OPC_AUIPC: legal_o = 1'b1;
            rv_trace_pkg::OPC_JAL:   legal_o = (imm_j[1:0] == 2'b00);
            rv_trace_pkg::OPC_JALR:  legal_o = (funct3 == 3'b000) && (imm_i[1:0] == 2'b00);
            rv_trace_pkg::OPC_B: begin
                // funct3 010 and 011 are reserved
                legal_o = (funct3 inside {3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111})
                          && (imm_b[1:0] == 2'b00);
            end
            rv_trace_pkg::OPC_IL:    legal_o = funct3 inside {3'b000, 3'b001, 3'b010,
                                                              3'b100, 3'b101};
            rv_trace_pkg::OPC_S:     legal_o = funct3 inside {3'b000, 3'b001, 3'b010};
            rv_trace_pkg::OPC_I: begin
                case (funct3)
                    3'b001:  legal_o = (funct == rv_trace_pkg::FN_SLLI);
                    3'b101:  legal_o = (funct == rv_trace_pkg::FN_SRLI) ||
                                       (funct == rv_trace_pkg::FN_SRAI);
                    default: legal_o = 1'b1;  // Upper bits are immediate
                endcase
            end
            rv_trace_pkg::OPC_R: begin
                legal_o = funct inside {rv_trace_pkg::FN_ADD, rv_trace_pkg::FN_SUB,
                                        rv_trace_pkg::FN_SLL, rv_trace_pkg::FN_SLT,
                                        rv_trace_pkg::FN_SLTU, rv_trace_pkg::FN_XOR,
                                        rv_trace_pkg::FN_SRL, rv_trace_pkg::FN_SRA,
                                        rv_trace_pkg::FN_OR, rv_trace_pkg::FN_AND};
            end
            rv_trace_pkg::OPC_FENCE: legal_o = (funct3 == 3'b000);  // Includes FENCE.TSO, PAUSE
            rv_trace_pkg::OPC_E:     legal_o = sys_ok;
            default:                 legal_o = 1'b0;
        endcase
    end

endmodule

/* design/rv_pipe_follower.sv */
`timescale 1ns/1ps

module rv_pipe_follower (
    input  logic                clk,
    input  logic                rst,
    input  rv_trace_pkg::inst_t fetch_inst_i,
    input  rv_trace_pkg::addr_t fetch_pc_i,
    input  logic                fetch_valid_i,
    input  logic                fetch_legal_i,
    input  logic                pd_flush_i,
    input  logic                bu_flush_i,
    input  logic                pd_stall_i,
    input  logic                id_stall_i,
    input  logic                ex_stall_i,
    input  logic                wb_stall_i,
    output rv_trace_pkg::inst_t wb_inst_o,
    output rv_trace_pkg::addr_t wb_pc_o,
    output logic                wb_bubble_o,
    output logic                retire_o,
    output logic                retire_illegal_o
);

    rv_trace_pkg::stage_t if_q;
    rv_trace_pkg::stage_t pd_q;
    rv_trace_pkg::stage_t id_q;
    rv_trace_pkg::stage_t ex_q;
    rv_trace_pkg::stage_t mem_q;
    rv_trace_pkg::stage_t wb_q;
    logic                 id_bubble;  // ID bubble as seen by EX
    logic                 wb_load_q;

    assign id_bubble = id_q.bubble | ex_stall_i | bu_flush_i;

    // Fetch to IF
    always_ff @(posedge clk) begin
        if (rst) begin
            if_q <= rv_trace_pkg::STAGE_INIT;
        end else begin
            if (!pd_stall_i) begin
                if_q <= '{inst: fetch_inst_i, pc: fetch_pc_i, legal: fetch_legal_i,
                          bubble: !fetch_valid_i};
            end
            if (pd_flush_i) begin
                if_q.bubble <= 1'b1;
            end
        end
    end

    // IF to PD
    always_ff @(posedge clk) begin
        if (rst) begin
            pd_q <= rv_trace_pkg::STAGE_INIT;
        end else begin
            if (!id_stall_i) begin
                pd_q <= if_q;
            end
            if (bu_flush_i) begin
                pd_q.bubble <= 1'b1;
            end
        end
    end

    // PD to ID where a load-use stall inserts a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            id_q <= rv_trace_pkg::STAGE_INIT;
        end else begin
            if (!ex_stall_i) begin
                id_q <= '{inst: pd_q.inst, pc: pd_q.pc, legal: pd_q.legal,
                          bubble: pd_q.bubble | id_stall_i};
            end
            if (bu_flush_i) begin
                id_q.bubble <= 1'b1;
            end
        end
    end

    // ID to EX
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_q <= rv_trace_pkg::STAGE_INIT;
        end else if (!ex_stall_i) begin
            ex_q <= '{inst: id_q.inst, pc: id_q.pc, legal: id_q.legal, bubble: id_bubble};
        end else begin
            ex_q.bubble <= 1'b1;  // Instruction already moved on to MEM
        end
    end

    // EX to MEM to WB share the WB stall
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_q     <= rv_trace_pkg::STAGE_INIT;
            wb_q      <= rv_trace_pkg::STAGE_INIT;
            wb_load_q <= 1'b0;
        end else begin
            if (!wb_stall_i) begin
                mem_q <= ex_q;
                wb_q  <= mem_q;
            end
            wb_load_q <= !wb_stall_i;
        end
    end

    assign wb_inst_o   = wb_q.inst;
    assign wb_pc_o     = wb_q.pc;
    assign wb_bubble_o = wb_q.bubble;

    // One pulse per payload entering WB
    assign retire_o         = wb_load_q & !wb_q.bubble;
    assign retire_illegal_o = retire_o & !wb_q.legal;

    // A retirement must come from a real instruction that left MEM on the last edge
    retire_from_mem : assert property (@(posedge clk) disable iff (rst)
        retire_o |-> $past(!mem_q.bubble && !wb_stall_i));

endmodule

/* design/rv_trace_regs.sv */
`timescale 1ns/1ps

module rv_trace_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  rv_trace_pkg::addr_t paddr_i,
    input  rv_trace_pkg::addr_t pwdata_i,
    input  logic                retire_i,
    input  logic                retire_illegal_i,
    input  rv_trace_pkg::inst_t wb_inst_i,
    input  rv_trace_pkg::addr_t wb_pc_i,
    output rv_trace_pkg::addr_t prdata_o,
    output logic                pready_o,
    output logic                pslverr_o,
    output logic                irq_o
);

    logic                ctrl_en_q;
    logic                ctrl_irq_en_q;
    rv_trace_pkg::addr_t retired_cnt_q;
    rv_trace_pkg::addr_t illegal_cnt_q;
    rv_trace_pkg::addr_t last_pc_q;
    logic                access;
    logic                wr_en;
    logic                rd_en;
    logic                mapped;
    rv_trace_pkg::addr_t rd_data;

    assign access = psel_i & penable_i;  // APB access phase
    assign wr_en  = access & pwrite_i;
    assign rd_en  = access & !pwrite_i;

    // Address decode and read mux
    always_comb begin
        mapped  = 1'b1;
        rd_data = '0;
        case (paddr_i)
            rv_trace_pkg::REG_CTRL:    rd_data = {30'd0, ctrl_irq_en_q, ctrl_en_q};
            rv_trace_pkg::REG_RETIRED: rd_data = retired_cnt_q;
            rv_trace_pkg::REG_ILLEGAL: rd_data = illegal_cnt_q;
            rv_trace_pkg::REG_LAST_PC: rd_data = last_pc_q;
            rv_trace_pkg::REG_WB_INST: rd_data = wb_inst_i;
            rv_trace_pkg::REG_WB_PC:   rd_data = wb_pc_i;
            default:                   mapped  = 1'b0;
        endcase
    end

    assign prdata_o  = rd_en ? rd_data : '0;
    assign pready_o  = 1'b1;  // No wait states
    assign pslverr_o = access & !mapped;

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_en_q     <= 1'b0;
            ctrl_irq_en_q <= 1'b0;
        end else if (wr_en && paddr_i == rv_trace_pkg::REG_CTRL) begin
            ctrl_en_q     <= pwdata_i[0];
            ctrl_irq_en_q <= pwdata_i[1];
        end
    end

    // Clear by write wins over a same-cycle retirement
    always_ff @(posedge clk) begin
        if (rst) begin
            retired_cnt_q <= '0;
        end else if (wr_en && paddr_i == rv_trace_pkg::REG_RETIRED) begin
            retired_cnt_q <= '0;
        end else if (ctrl_en_q && retire_i) begin
            retired_cnt_q <= retired_cnt_q + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            illegal_cnt_q <= '0;
            last_pc_q     <= '0;
        end else begin
            if (wr_en && paddr_i == rv_trace_pkg::REG_ILLEGAL) begin
                illegal_cnt_q <= '0;
            end else if (ctrl_en_q && retire_illegal_i) begin
                illegal_cnt_q <= illegal_cnt_q + 32'd1;
            end
            if (ctrl_en_q && retire_illegal_i) begin
                last_pc_q <= wb_pc_i;  // WB still holds the retiring PC
            end
        end
    end

    assign irq_o = ctrl_irq_en_q & (illegal_cnt_q != '0);

    // Every access phase follows a setup phase
    apb_setup_first : assert property (@(posedge clk) disable iff (rst)
        penable_i |-> psel_i && $past(psel_i));

endmodule

/* design/rv_trace_monitor.sv */
`timescale 1ns/1ps

module rv_trace_monitor (
    input  logic                clk,
    input  logic                rst,
    input  rv_trace_pkg::inst_t fetch_inst_i,
    input  rv_trace_pkg::addr_t fetch_pc_i,
    input  logic                fetch_valid_i,
    input  logic                pd_flush_i,
    input  logic                bu_flush_i,
    input  logic                pd_stall_i,
    input  logic                id_stall_i,
    input  logic                ex_stall_i,
    input  logic                wb_stall_i,
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  rv_trace_pkg::addr_t paddr_i,
    input  rv_trace_pkg::addr_t pwdata_i,
    output rv_trace_pkg::addr_t prdata_o,
    output logic                pready_o,
    output logic                pslverr_o,
    output logic                irq_o,
    output rv_trace_pkg::inst_t wb_inst_o,
    output rv_trace_pkg::addr_t wb_pc_o,
    output logic                wb_bubble_o
);

    logic fetch_legal;
    logic retire;
    logic retire_illegal;

    rv_inst_legality i_rv_inst_legality (
        .inst_i  (fetch_inst_i),
        .legal_o (fetch_legal)
    );

    rv_pipe_follower i_rv_pipe_follower (
        .clk              (clk),
        .rst              (rst),
        .fetch_inst_i     (fetch_inst_i),
        .fetch_pc_i       (fetch_pc_i),
        .fetch_valid_i    (fetch_valid_i),
        .fetch_legal_i    (fetch_legal),
        .pd_flush_i       (pd_flush_i),
        .bu_flush_i       (bu_flush_i),
        .pd_stall_i       (pd_stall_i),
        .id_stall_i       (id_stall_i),
        .ex_stall_i       (ex_stall_i),
        .wb_stall_i       (wb_stall_i),
        .wb_inst_o        (wb_inst_o),
        .wb_pc_o          (wb_pc_o),
        .wb_bubble_o      (wb_bubble_o),
        .retire_o         (retire),
        .retire_illegal_o (retire_illegal)
    );

    rv_trace_regs i_rv_trace_regs (
        .clk              (clk),
        .rst              (rst),
        .psel_i           (psel_i),
        .penable_i        (penable_i),
        .pwrite_i         (pwrite_i),
        .paddr_i          (paddr_i),
        .pwdata_i         (pwdata_i),
        .retire_i         (retire),
        .retire_illegal_i (retire_illegal),
        .wb_inst_i        (wb_inst_o),
        .wb_pc_i          (wb_pc_o),
        .prdata_o         (prdata_o),
        .pready_o         (pready_o),
        .pslverr_o        (pslverr_o),
        .irq_o            (irq_o)
    );

endmodule

/* bench/rv_trace_tasks.svh */
rv_trace_pkg::stage_t stage_m [6];  // IF, PD, ID, EX, MEM, WB
logic                 en_m;
logic                 pend_ret;      // Retirement seen by the counters next edge
logic                 pend_ill;
rv_trace_pkg::addr_t  pend_pc;
rv_trace_pkg::addr_t  exp_retired;
rv_trace_pkg::addr_t  exp_illegal;
rv_trace_pkg::addr_t  exp_last_pc;

rv_trace_pkg::inst_t legal_set [14] = '{
    32'h00500093, 32'h002081b3, 32'h40208233, 32'h123452b7, 32'h00001317,
    32'h008000ef, 32'h00208463, 32'h0040a383, 32'h0070a423, 32'h0000000f,
    32'h00000073, 32'h00100073, 32'h00008067, 32'h4010d093
};
// Zero word, all ones, odd JAL offset, reserved branch, MUL, odd JALR offset
rv_trace_pkg::inst_t illegal_set [6] = '{
    32'h00000000, 32'hffffffff, 32'h002000ef, 32'h0020a463, 32'h022081b3, 32'h00100067
};

task automatic check_inst(string name, rv_trace_pkg::inst_t got, rv_trace_pkg::inst_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("error %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic check_addr(string name, rv_trace_pkg::addr_t got, rv_trace_pkg::addr_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("error %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic check_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("error %s: got %h, expected %h", name, got, exp);
    end
endtask

// Reference decode straight from the RV32I encoding tables
function automatic logic sw_legal(rv_trace_pkg::inst_t w);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = w[14:12];
    f7 = w[31:25];
    case (w[6:0])
        7'h37, 7'h17: return 1'b1;
        7'h6f:        return !w[21];                      // J offset bit 1
        7'h67:        return f3 == 3'd0 && w[21:20] == 2'd0;
        7'h63:        return f3[2:1] != 2'b01 && !w[8];   // B offset bit 1
        7'h03:        return f3 != 3'd3 && f3 < 3'd6;
        7'h23:        return f3 <= 3'd2;
        7'h13: begin
            if (f3 == 3'd1) return f7 == 7'h00;
            if (f3 == 3'd5) return f7 == 7'h00 || f7 == 7'h20;
            return 1'b1;
        end
        7'h33:        return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        7'h0f:        return f3 == 3'd0;
        7'h73:        return w[31:21] == 11'd0 && w[19:7] == 13'd0;
        default:      return 1'b0;
    endcase
endfunction

task automatic model_reset();
    foreach (stage_m[i]) begin
        stage_m[i] = '{inst: rv_trace_pkg::NOP, pc: rv_trace_pkg::PC_INIT,
                       legal: 1'b1, bubble: 1'b1};
    end
    en_m        = 1'b0;
    pend_ret    = 1'b0;
    pend_ill    = 1'b0;
    pend_pc     = '0;
    exp_retired = '0;
    exp_illegal = '0;
    exp_last_pc = '0;
endtask

// Stages update from WB back to IF so each reads its old predecessor
task automatic model_step();
    if (en_m && pend_ret) begin
        exp_retired++;
        if (pend_ill) begin
            exp_illegal++;
            exp_last_pc = pend_pc;
        end
    end
    pend_ret = 1'b0;
    if (!wb_stall) begin
        stage_m[5] = stage_m[4];
        stage_m[4] = stage_m[3];
        pend_ret   = !stage_m[5].bubble;
    end
    if (!ex_stall) begin
        stage_m[3]        = stage_m[2];
        stage_m[3].bubble = stage_m[2].bubble | bu_flush;
        stage_m[2]        = stage_m[1];
        stage_m[2].bubble = stage_m[1].bubble | id_stall;
    end else begin
        stage_m[3].bubble = 1'b1;
    end
    if (bu_flush) stage_m[2].bubble = 1'b1;
    if (!id_stall) stage_m[1] = stage_m[0];
    if (bu_flush) stage_m[1].bubble = 1'b1;
    if (!pd_stall) begin
        stage_m[0] = '{inst: fetch_inst, pc: fetch_pc, legal: sw_legal(fetch_inst),
                       bubble: !fetch_valid};
    end
    if (pd_flush) stage_m[0].bubble = 1'b1;
    pend_ill = pend_ret && !stage_m[5].legal;
    pend_pc  = stage_m[5].pc;
endtask

// Called and returns 2 ns after a rising edge
task automatic apb_write(rv_trace_pkg::addr_t addr, rv_trace_pkg::addr_t data);
    psel   = 1'b1;
    pwrite = 1'b1;
    paddr  = addr;
    pwdata = data;
    @(posedge clk);
    #2;
    penable = 1'b1;
    #1;
    check_bit("pready_o", pready, 1'b1);
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    if (addr == rv_trace_pkg::REG_CTRL) en_m = data[0];
    if (addr == rv_trace_pkg::REG_RETIRED) exp_retired = '0;
    if (addr == rv_trace_pkg::REG_ILLEGAL) exp_illegal = '0;
endtask

task automatic apb_read(rv_trace_pkg::addr_t addr, output rv_trace_pkg::addr_t data,
                        output logic err);
    psel   = 1'b1;
    pwrite = 1'b0;
    paddr  = addr;
    @(posedge clk);
    #2;
    penable = 1'b1;
    #1;
    check_bit("pready_o", pready, 1'b1);
    data = prdata;  // Combinational in the access cycle
    err  = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
endtask

task automatic read_check(rv_trace_pkg::addr_t addr, rv_trace_pkg::addr_t exp, string name);
    rv_trace_pkg::addr_t data;
    logic                err;
    apb_read(addr, data, err);
    check_addr(name, data, exp);
    check_bit("pslverr_o", err, 1'b0);
endtask

// ctl is {pd_flush, bu_flush, pd_stall, id_stall, ex_stall, wb_stall}
task automatic fetch_cycle(rv_trace_pkg::inst_t inst, rv_trace_pkg::addr_t pc, logic valid,
                           logic [5:0] ctl);
    fetch_inst  = inst;
    fetch_pc    = pc;
    fetch_valid = valid;
    {pd_flush, bu_flush, pd_stall, id_stall, ex_stall, wb_stall} = ctl;
    @(posedge clk);
    #2;
endtask

task automatic drain(int n);
    repeat (n) fetch_cycle(rv_trace_pkg::NOP, '0, 1'b0, 6'd0);
endtask

task automatic test_reset_values();
    check_inst("wb_inst_o", wb_inst, rv_trace_pkg::NOP);
    check_addr("wb_pc_o", wb_pc, rv_trace_pkg::PC_INIT);
    check_bit("wb_bubble_o", wb_bubble, 1'b1);
    check_bit("irq_o", irq, 1'b0);
    // WB keeps its reset payload for the first five edges
    read_check(rv_trace_pkg::REG_WB_INST, rv_trace_pkg::NOP, "prdata_o wb_inst");
    read_check(rv_trace_pkg::REG_WB_PC, rv_trace_pkg::PC_INIT, "prdata_o wb_pc");
    read_check(rv_trace_pkg::REG_CTRL, '0, "prdata_o ctrl");
    read_check(rv_trace_pkg::REG_RETIRED, '0, "prdata_o retired");
    read_check(rv_trace_pkg::REG_ILLEGAL, '0, "prdata_o illegal");
    read_check(rv_trace_pkg::REG_LAST_PC, '0, "prdata_o last_pc");
endtask

task automatic test_in_order_flow();
    rv_trace_pkg::inst_t hist_inst [14];
    rv_trace_pkg::addr_t hist_pc [14];
    int                  n = 14;
    apb_write(rv_trace_pkg::REG_CTRL, 32'h1);
    for (int j = 0; j < n + 5; j++) begin
        if (j < n) begin
            hist_inst[j] = legal_set[j];
            hist_pc[j]   = 32'h1000 + 4 * j;
            fetch_cycle(hist_inst[j], hist_pc[j], 1'b1, 6'd0);
        end else begin
            fetch_cycle(rv_trace_pkg::NOP, '0, 1'b0, 6'd0);
        end
        if (j >= 5) begin  // Fetch at edge j-5 is in WB now
            check_inst("wb_inst_o", wb_inst, hist_inst[j-5]);
            check_addr("wb_pc_o", wb_pc, hist_pc[j-5]);
            check_bit("wb_bubble_o", wb_bubble, 1'b0);
        end
    end
    drain(2);
    read_check(rv_trace_pkg::REG_RETIRED, n, "prdata_o retired");
    read_check(rv_trace_pkg::REG_ILLEGAL, '0, "prdata_o illegal");
endtask

task automatic test_legality_count();
    rv_trace_pkg::inst_t word;
    for (int i = 0; i < 48; i++) begin
        case (i % 3)
            0:       word = legal_set[i % 14];
            1:       word = $random(seed);
            default: word = illegal_set[(i / 3) % 6];
        endcase
        fetch_cycle(word, 32'h2000 + 4 * i, 1'b1, 6'd0);
    end
    drain(7);
    read_check(rv_trace_pkg::REG_RETIRED, exp_retired, "prdata_o retired");
    read_check(rv_trace_pkg::REG_ILLEGAL, exp_illegal, "prdata_o illegal");
    read_check(rv_trace_pkg::REG_LAST_PC, exp_last_pc, "prdata_o last_pc");
    check_bit("irq_o", irq, 1'b0);
    apb_write(rv_trace_pkg::REG_CTRL, 32'h3);
    check_bit("irq_o", irq, exp_illegal != 0);
endtask

task automatic test_stall_flush();
    rv_trace_pkg::inst_t word;
    logic [5:0]          ctl;
    int                  r;
    for (int i = 0; i < 1600; i++) begin
        r   = $random(seed);
        ctl = {r[3:0] == 0, r[7:4] == 0, r[10:8] == 0,    // Flushes rarer than stalls
               r[13:11] == 0, r[16:14] == 0, r[19:17] == 0};
        word = r[20] ? rv_trace_pkg::inst_t'($random(seed)) : legal_set[r[24:21] % 14];
        fetch_cycle(word, 32'h4000 + 4 * i, r[25] | r[26], ctl);
    end
    drain(8);
    read_check(rv_trace_pkg::REG_RETIRED, exp_retired, "prdata_o retired");
    read_check(rv_trace_pkg::REG_ILLEGAL, exp_illegal, "prdata_o illegal");
    read_check(rv_trace_pkg::REG_LAST_PC, exp_last_pc, "prdata_o last_pc");
endtask

task automatic test_clear_and_errors();
    rv_trace_pkg::addr_t data;
    logic                err;
    apb_write(rv_trace_pkg::REG_RETIRED, 32'hdead_beef);
    apb_write(rv_trace_pkg::REG_ILLEGAL, 32'h1);
    read_check(rv_trace_pkg::REG_RETIRED, '0, "prdata_o retired");
    read_check(rv_trace_pkg::REG_ILLEGAL, '0, "prdata_o illegal");
    check_bit("irq_o", irq, 1'b0);
    apb_write(rv_trace_pkg::REG_CTRL, 32'h0);
    for (int i = 0; i < 10; i++) begin
        fetch_cycle(i[0] ? illegal_set[i % 6] : legal_set[i], 32'h6000 + 4 * i, 1'b1, 6'd0);
    end
    drain(7);
    read_check(rv_trace_pkg::REG_RETIRED, '0, "prdata_o retired");
    read_check(rv_trace_pkg::REG_ILLEGAL, '0, "prdata_o illegal");
    read_check(rv_trace_pkg::REG_LAST_PC, exp_last_pc, "prdata_o last_pc");
    apb_read(32'h18, data, err);
    check_bit("pslverr_o", err, 1'b1);
    apb_read(32'h100, data, err);
    check_bit("pslverr_o", err, 1'b1);
endtask

/* bench/rv_trace_monitor_tb.sv */
`timescale 1ns/1ps

module rv_trace_monitor_tb;

    localparam int MAX_CYCLES = 4000;  // Roughly twice the full test sequence

    logic                clk;
    logic                rst;
    rv_trace_pkg::inst_t fetch_inst;
    rv_trace_pkg::addr_t fetch_pc;
    logic                fetch_valid;
    logic                pd_flush;
    logic                bu_flush;
    logic                pd_stall;
    logic                id_stall;
    logic                ex_stall;
    logic                wb_stall;
    logic                psel;
    logic                penable;
    logic                pwrite;
    rv_trace_pkg::addr_t paddr;
    rv_trace_pkg::addr_t pwdata;
    rv_trace_pkg::addr_t prdata;
    logic                pready;
    logic                pslverr;
    logic                irq;
    rv_trace_pkg::inst_t wb_inst;
    rv_trace_pkg::addr_t wb_pc;
    logic                wb_bubble;
    int                  errors;
    int                  checks;
    int                  cycles;
    int                  seed;
    logic                track;  // WB comparison against the model

    `include "rv_trace_tasks.svh"

    rv_trace_monitor i_rv_trace_monitor (
        .clk          (clk),
        .rst          (rst),
        .fetch_inst_i (fetch_inst),
        .fetch_pc_i   (fetch_pc),
        .fetch_valid_i(fetch_valid),
        .pd_flush_i   (pd_flush),
        .bu_flush_i   (bu_flush),
        .pd_stall_i   (pd_stall),
        .id_stall_i   (id_stall),
        .ex_stall_i   (ex_stall),
        .wb_stall_i   (wb_stall),
        .psel_i       (psel),
        .penable_i    (penable),
        .pwrite_i     (pwrite),
        .paddr_i      (paddr),
        .pwdata_i     (pwdata),
        .prdata_o     (prdata),
        .pready_o     (pready),
        .pslverr_o    (pslverr),
        .irq_o        (irq),
        .wb_inst_o    (wb_inst),
        .wb_pc_o      (wb_pc),
        .wb_bubble_o  (wb_bubble)
    );

    always #20 clk = !clk;

    // Follower model advances on the same edge as the DUT
    always @(posedge clk) begin
        if (rst) begin
            model_reset();
        end else begin
            model_step();
        end
    end

    always @(negedge clk) begin
        if (track) begin
            check_inst("wb_inst_o", wb_inst, stage_m[5].inst);
            check_addr("wb_pc_o", wb_pc, stage_m[5].pc);
            check_bit("wb_bubble_o", wb_bubble, stage_m[5].bubble);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        seed        = 32'h72ec;
        track       = 1'b0;
        fetch_inst  = rv_trace_pkg::NOP;
        fetch_pc    = '0;
        fetch_valid = 1'b0;
        pd_flush    = 1'b0;
        bu_flush    = 1'b0;
        pd_stall    = 1'b0;
        id_stall    = 1'b0;
        ex_stall    = 1'b0;
        wb_stall    = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        repeat (10) @(posedge clk);
        #2;
        rst   = 1'b0;
        track = 1'b1;
        test_reset_values();
        test_in_order_flow();
        test_legality_count();
        test_stall_flush();
        test_clear_and_errors();
        $display("Errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* rv_trace_monitor.f */
+incdir+bench
design/rv_trace_pkg.sv
design/rv_inst_legality.sv
design/rv_pipe_follower.sv
design/rv_trace_regs.sv
design/rv_trace_monitor.sv
bench/rv_trace_monitor_tb.sv

/* Bender.yml */
package:
  name: rv_trace_monitor

sources:
  - design/rv_trace_pkg.sv
  - design/rv_inst_legality.sv
  - design/rv_pipe_follower.sv
  - design/rv_trace_regs.sv
  - design/rv_trace_monitor.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/rv_trace_monitor_tb.sv
